//--- eth_crc_8.sv
// ==========================================================
// eth_crc_8
// one byte step of the reflected ethernet crc-32
// eight chained bit-serial stages, purely combinational
// ==========================================================

`timescale 1ns/1ps

module eth_crc_8 (
    input  logic [7:0]  data_in,
    input  logic [31:0] crc_state,
    output logic [31:0] crc_next
);

    // crc value after each bit, step[0] is the incoming state
    logic [31:0] step [9];
    // xor of the shifted-out bit and the data bit, per stage
    logic [7:0]  feedback;

    assign step[0] = crc_state;

    // bits go in lsb first, as they leave the wire
    for (genvar g = 0; g < 8; g++) begin : g_bit
        assign feedback[g] = step[g][0] ^ data_in[g];

        // shift right, fold the polynomial in when feedback is set
        assign step[g+1] = {1'b0, step[g][31:1]}
                         ^ ({32{feedback[g]}} & eth_rx_pkg::crc_poly);
    end

    assign crc_next = step[8];

endmodule

//--- eth_mac_rx_top.sv
// ==========================================================
// eth_mac_rx_top
// 1 Gb/s ethernet mac receive path
// gmii in, payload byte stream and statistics out
// ==========================================================

`timescale 1ns/1ps

module eth_mac_rx_top (
    input  logic                              clk,
    input  logic                              reset_crc,
    input  logic [7:0]                        gmii_rxd,
    input  logic                              gmii_rx_dv,
    input  logic                              gmii_rx_er,
    output logic [7:0]                        m_axis_tdata,
    output logic                              m_axis_tvalid,
    output logic                              m_axis_tlast,
    output logic                              m_axis_tuser,
    output logic                              error_bad_frame,
    output logic                              error_bad_fcs,
    output logic [eth_rx_pkg::stat_width-1:0] cnt_good,
    output logic [eth_rx_pkg::stat_width-1:0] cnt_bad,
    output logic [eth_rx_pkg::stat_width-1:0] cnt_fcs
);

    // decode to frame FSM
    logic [7:0]  rx_byte;
    logic        rx_sfd;
    logic [31:0] fcs_window;
    logic        rx_end;
    logic        rx_abort;

    gmii_rx_decode u_decode (
        .clk        (clk),
        .reset_crc  (reset_crc),
        .gmii_rxd   (gmii_rxd),
        .gmii_rx_dv (gmii_rx_dv),
        .gmii_rx_er (gmii_rx_er),
        .rx_byte    (rx_byte),
        .rx_sfd     (rx_sfd),
        .fcs_window (fcs_window),
        .rx_end     (rx_end),
        .rx_abort   (rx_abort)
    );

    eth_rx_frame u_frame (
        .clk             (clk),
        .reset_crc       (reset_crc),
        .rx_byte         (rx_byte),
        .rx_sfd          (rx_sfd),
        .fcs_window      (fcs_window),
        .rx_end          (rx_end),
        .rx_abort        (rx_abort),
        .m_axis_tdata    (m_axis_tdata),
        .m_axis_tvalid   (m_axis_tvalid),
        .m_axis_tlast    (m_axis_tlast),
        .m_axis_tuser    (m_axis_tuser),
        .error_bad_frame (error_bad_frame),
        .error_bad_fcs   (error_bad_fcs)
    );

    eth_rx_stats u_stats (
        .clk             (clk),
        .reset_crc       (reset_crc),
        .m_axis_tvalid   (m_axis_tvalid),
        .m_axis_tlast    (m_axis_tlast),
        .error_bad_frame (error_bad_frame),
        .error_bad_fcs   (error_bad_fcs),
        .cnt_good        (cnt_good),
        .cnt_bad         (cnt_bad),
        .cnt_fcs         (cnt_fcs)
    );

endmodule

//--- eth_rx_frame.sv
// ==========================================================
// eth_rx_frame
// receive frame FSM with the running crc-32
// emits payload bytes as a stream, checks the fcs at the
// end and marks bad or aborted frames on the last beat
// ==========================================================

`timescale 1ns/1ps

module eth_rx_frame (
    input  logic        clk,
    input  logic        reset_crc,
    input  logic [7:0]  rx_byte,
    input  logic        rx_sfd,
    input  logic [31:0] fcs_window,
    input  logic        rx_end,
    input  logic        rx_abort,
    output logic [7:0]  m_axis_tdata,
    output logic        m_axis_tvalid,
    output logic        m_axis_tlast,
    output logic        m_axis_tuser,
    output logic        error_bad_frame,
    output logic        error_bad_fcs
);

    typedef enum logic [1:0] {
        st_idle,
        st_payload,
        st_wait_end
    } state_t;

    state_t      state;
    logic [31:0] crc_state;
    logic [31:0] crc_next;
    logic        fcs_bad;
    // abort seen on the pins before the payload reached the FSM
    logic        abort_pend;

    eth_crc_8 u_crc (
        .data_in   (rx_byte),
        .crc_state (crc_state),
        .crc_next  (crc_next)
    );

    // the fcs is the inverted crc over the payload
    assign fcs_bad = (fcs_window != ~crc_next);

    // output byte follows the delay line
    always_ff @(posedge clk) begin
        m_axis_tdata <= rx_byte;
    end

    always_ff @(posedge clk) begin
        if (reset_crc) begin
            state           <= st_idle;
            crc_state       <= eth_rx_pkg::crc_init;
            abort_pend      <= 1'b0;
            m_axis_tvalid   <= 1'b0;
            m_axis_tlast    <= 1'b0;
            m_axis_tuser    <= 1'b0;
            error_bad_frame <= 1'b0;
            error_bad_fcs   <= 1'b0;
        end else begin
            // strobes default low
            m_axis_tvalid   <= 1'b0;
            m_axis_tlast    <= 1'b0;
            m_axis_tuser    <= 1'b0;
            error_bad_frame <= 1'b0;
            error_bad_fcs   <= 1'b0;

            case (state)
                st_idle: begin
                    crc_state <= eth_rx_pkg::crc_init;
                    if (rx_end) begin
                        abort_pend <= 1'b0;
                    end else if (rx_abort) begin
                        abort_pend <= 1'b1;
                    end
                    if (rx_sfd) begin
                        state <= st_payload;
                    end
                end

                st_payload: begin
                    crc_state     <= crc_next;
                    m_axis_tvalid <= 1'b1;
                    if (rx_abort || abort_pend) begin
                        // cut the frame short as bad, no fcs verdict
                        m_axis_tlast    <= 1'b1;
                        m_axis_tuser    <= 1'b1;
                        error_bad_frame <= 1'b1;
                        abort_pend      <= 1'b0;
                        state           <= rx_end ? st_idle : st_wait_end;
                    end else if (rx_end) begin
                        // pins dropped dv, fcs sits in the window
                        m_axis_tlast <= 1'b1;
                        if (fcs_bad) begin
                            m_axis_tuser    <= 1'b1;
                            error_bad_frame <= 1'b1;
                            error_bad_fcs   <= 1'b1;
                        end
                        state <= st_idle;
                    end
                end

                st_wait_end: begin
                    // rest of an aborted frame is dropped
                    crc_state <= eth_rx_pkg::crc_init;
                    if (rx_end) begin
                        state <= st_idle;
                    end
                end

                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    a_last_valid: assert property (@(posedge clk) disable iff (reset_crc)
        m_axis_tlast |-> m_axis_tvalid);

    // an fcs error is always a bad frame reported on its last beat
    a_fcs_bad_frame: assert property (@(posedge clk) disable iff (reset_crc)
        error_bad_fcs |-> error_bad_frame && m_axis_tlast && m_axis_tuser);

endmodule

//--- eth_rx_pkg.sv
// ==========================================================
// eth_rx_pkg
// shared constants for the gigabit ethernet receive path
// crc-32 values, delimiter, delay depth and counter width
// ==========================================================

package eth_rx_pkg;

    // reflected crc-32 as used for the ethernet fcs
    localparam logic [31:0] crc_init = 32'hFFFF_FFFF;
    localparam logic [31:0] crc_poly = 32'hEDB8_8320;

    // start-frame delimiter that follows the 0x55 preamble
    localparam logic [7:0] sfd_byte = 8'hD5;

    // fcs length in bytes
    localparam int fcs_bytes = 4;

    // stages between the gmii pins and the byte seen by the frame FSM
    // one more than the fcs so the last payload byte is at the output
    // while the whole fcs still sits in the window
    localparam int rx_delay_depth = fcs_bytes + 1;

    // statistics counter width
    localparam int stat_width = 16;

endpackage

//--- eth_rx_stats.sv
// ==========================================================
// eth_rx_stats
// saturating receive counters
// good frames, bad frames and fcs errors per last beat
// ==========================================================

`timescale 1ns/1ps

module eth_rx_stats (
    input  logic                              clk,
    input  logic                              reset_crc,
    input  logic                              m_axis_tvalid,
    input  logic                              m_axis_tlast,
    input  logic                              error_bad_frame,
    input  logic                              error_bad_fcs,
    output logic [eth_rx_pkg::stat_width-1:0] cnt_good,
    output logic [eth_rx_pkg::stat_width-1:0] cnt_bad,
    output logic [eth_rx_pkg::stat_width-1:0] cnt_fcs
);

    logic last_beat;

    // increment that sticks at all ones
    function automatic logic [eth_rx_pkg::stat_width-1:0] sat_inc(
        input logic [eth_rx_pkg::stat_width-1:0] v
    );
        return (&v) ? v : v + 1'b1;
    endfunction

    assign last_beat = m_axis_tvalid && m_axis_tlast;

    always_ff @(posedge clk) begin
        if (reset_crc) begin
            cnt_good <= '0;
            cnt_bad  <= '0;
            cnt_fcs  <= '0;
        end else if (last_beat) begin
            if (error_bad_frame) begin
                cnt_bad <= sat_inc(cnt_bad);
            end else begin
                cnt_good <= sat_inc(cnt_good);
            end
            if (error_bad_fcs) begin
                cnt_fcs <= sat_inc(cnt_fcs);
            end
        end
    end

    // once full a counter stays full
    property p_no_wrap(logic [eth_rx_pkg::stat_width-1:0] cnt);
        @(posedge clk) disable iff (reset_crc)
            (&cnt) |=> (&cnt);
    endproperty

    a_good_no_wrap: assert property (p_no_wrap(cnt_good));
    a_bad_no_wrap:  assert property (p_no_wrap(cnt_bad));
    a_fcs_no_wrap:  assert property (p_no_wrap(cnt_fcs));

endmodule

//--- gmii_rx_decode.sv
// ==========================================================
// gmii_rx_decode
// gmii receive alignment and delimiter detection
// delays the byte stream so the fcs is visible in a window
// when the pins end the frame, and flags end and abort
// ==========================================================

`timescale 1ns/1ps

module gmii_rx_decode (
    input  logic        clk,
    input  logic        reset_crc,
    input  logic [7:0]  gmii_rxd,
    input  logic        gmii_rx_dv,
    input  logic        gmii_rx_er,
    output logic [7:0]  rx_byte,
    output logic        rx_sfd,
    output logic [31:0] fcs_window,
    output logic        rx_end,
    output logic        rx_abort
);

    // rxd_d[0] is the newest byte
    logic [7:0] rxd_d [eth_rx_pkg::rx_delay_depth];
    logic [eth_rx_pkg::rx_delay_depth-1:0] dv_d;
    logic [eth_rx_pkg::rx_delay_depth-1:0] er_d;
    // set in the gap between frames, cleared once a delimiter is taken
    logic sfd_armed;

    // data stages
    always_ff @(posedge clk) begin
        rxd_d[0] <= gmii_rxd;
        for (int i = 1; i < eth_rx_pkg::rx_delay_depth; i++) begin
            rxd_d[i] <= rxd_d[i-1];
        end
    end

    // control stages
    always_ff @(posedge clk) begin
        if (reset_crc) begin
            dv_d      <= '0;
            er_d      <= '0;
            sfd_armed <= 1'b0;
        end else begin
            dv_d <= {dv_d[eth_rx_pkg::rx_delay_depth-2:0], gmii_rx_dv};
            er_d <= {er_d[eth_rx_pkg::rx_delay_depth-2:0], gmii_rx_er};

            // payload bytes equal to the sfd value must not restart a frame
            if (!dv_d[eth_rx_pkg::rx_delay_depth-1]) begin
                sfd_armed <= 1'b1;
            end else if (rx_sfd || er_d[eth_rx_pkg::rx_delay_depth-1]) begin
                sfd_armed <= 1'b0;
            end
        end
    end

    assign rx_byte = rxd_d[eth_rx_pkg::rx_delay_depth-1];

    assign rx_sfd = sfd_armed
                  && dv_d[eth_rx_pkg::rx_delay_depth-1]
                  && !er_d[eth_rx_pkg::rx_delay_depth-1]
                  && (rxd_d[eth_rx_pkg::rx_delay_depth-1] == eth_rx_pkg::sfd_byte);

    // first fcs byte on the wire lands in bits 7:0
    always_comb begin
        for (int i = 0; i < eth_rx_pkg::fcs_bytes; i++) begin
            fcs_window[8*(eth_rx_pkg::fcs_bytes-1-i) +: 8] = rxd_d[i];
        end
    end

    // look-ahead straight from the pins
    assign rx_end   = !gmii_rx_dv;
    assign rx_abort = gmii_rx_dv && gmii_rx_er;

    // errored byte never counts as a delimiter
    a_sfd_no_er: assert property (@(posedge clk) disable iff (reset_crc)
        rx_sfd |-> !$past(gmii_rx_er, eth_rx_pkg::rx_delay_depth));

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the receive MAC testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert -f src.f --top-module tb_eth_mac_rx -o tb_sim \
    > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/tb_sim > sim.log 2>&1 || echo "simulator exited with an error" >> sim.log
cat sim.log

grep -q "TESTS FAILED" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "TESTS PASSED" sim.log || { echo "simulation did not complete"; exit 1; }
echo "simulation passed"
exit 0

//--- src.f
eth_rx_pkg.sv
eth_crc_8.sv
gmii_rx_decode.sv
eth_rx_frame.sv
eth_rx_stats.sv
eth_mac_rx_top.sv
tb_eth_mac_rx.sv

//--- tb_eth_mac_rx.sv
// ==========================================================
// tb_eth_mac_rx
// table-driven testbench for the gigabit receive MAC
// drives gmii frames and checks the payload stream, the
// error strobes and the statistics against a reference crc
// ==========================================================

`timescale 1ns/1ps

module tb_eth_mac_rx;

    localparam int num_tests = 9;
    // row kinds
    localparam int kind_frame  = 0;
    localparam int kind_no_sfd = 1;
    localparam int kind_er_sfd = 2;

    logic                              clk;
    logic                              reset_crc;
    logic [7:0]                        gmii_rxd;
    logic                              gmii_rx_dv;
    logic                              gmii_rx_er;
    logic [7:0]                        m_axis_tdata;
    logic                              m_axis_tvalid;
    logic                              m_axis_tlast;
    logic                              m_axis_tuser;
    logic                              error_bad_frame;
    logic                              error_bad_fcs;
    logic [eth_rx_pkg::stat_width-1:0] cnt_good;
    logic [eth_rx_pkg::stat_width-1:0] cnt_bad;
    logic [eth_rx_pkg::stat_width-1:0] cnt_fcs;

    // stimulus table, abort -1 means none
    string      row_name    [num_tests];
    int         row_len     [num_tests];
    logic [7:0] row_start   [num_tests];
    logic       row_bad_fcs [num_tests];
    int         row_abort   [num_tests];
    int         row_kind    [num_tests];

    logic [7:0] payload [256];
    int         seed;
    int         cycle_cnt;
    int         first_drive_cycle;
    int         test_errors;
    int         total_errors;
    int         tests_failed;

    // collected stream beats
    logic [7:0] beat_data  [$];
    logic       beat_last  [$];
    logic       beat_user  [$];
    int         beat_cycle [$];
    logic       last_seen;
    int         bad_frame_pulses;
    int         bad_fcs_pulses;

    eth_mac_rx_top UUT (
        .clk             (clk),
        .reset_crc       (reset_crc),
        .gmii_rxd        (gmii_rxd),
        .gmii_rx_dv      (gmii_rx_dv),
        .gmii_rx_er      (gmii_rx_er),
        .m_axis_tdata    (m_axis_tdata),
        .m_axis_tvalid   (m_axis_tvalid),
        .m_axis_tlast    (m_axis_tlast),
        .m_axis_tuser    (m_axis_tuser),
        .error_bad_frame (error_bad_frame),
        .error_bad_fcs   (error_bad_fcs),
        .cnt_good        (cnt_good),
        .cnt_bad         (cnt_bad),
        .cnt_fcs         (cnt_fcs)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // stream monitor, sampled mid-cycle
    always @(negedge clk) begin
        if (!reset_crc) begin
            if (m_axis_tvalid) begin
                beat_data.push_back(m_axis_tdata);
                beat_last.push_back(m_axis_tlast);
                beat_user.push_back(m_axis_tuser);
                beat_cycle.push_back(cycle_cnt);
                if (m_axis_tlast) begin
                    last_seen = 1'b1;
                end
            end
            if (error_bad_frame) begin
                bad_frame_pulses++;
            end
            if (error_bad_fcs) begin
                bad_fcs_pulses++;
            end
        end
    end

    task automatic set_row(input int i, input string name, input int len,
                           input logic [7:0] start, input logic bad_fcs,
                           input int abort_at, input int kind);
        row_name[i]    = name;
        row_len[i]     = len;
        row_start[i]   = start;
        row_bad_fcs[i] = bad_fcs;
        row_abort[i]   = abort_at;
        row_kind[i]    = kind;
    endtask

    task automatic load_table();
        set_row(0, "good_1",       1,   8'h3C, 1'b0, -1, kind_frame);
        set_row(1, "good_46",      46,  8'hA5, 1'b0, -1, kind_frame);
        set_row(2, "good_200",     200, 8'h00, 1'b0, -1, kind_frame);
        set_row(3, "bad_fcs_64",   64,  8'h5A, 1'b1, -1, kind_frame);
        set_row(4, "abort_early",  40,  8'h11, 1'b0, 2,  kind_frame);
        set_row(5, "abort_mid",    80,  8'h22, 1'b0, 30, kind_frame);
        set_row(6, "noise_no_sfd", 30,  8'h33, 1'b0, -1, kind_no_sfd);
        set_row(7, "sfd_with_er",  30,  8'h44, 1'b0, -1, kind_er_sfd);
        set_row(8, "good_sfd_val", 60,  8'hD5, 1'b0, -1, kind_frame);
    endtask

    // reflected crc-32 over the payload, returned as the fcs word
    function automatic logic [31:0] fcs_of(input int len);
        logic [31:0] c;
        c = 32'hFFFF_FFFF;
        for (int i = 0; i < len; i++) begin
            c = c ^ {24'h0, payload[i]};
            for (int b = 0; b < 8; b++) begin
                c = c[0] ? ((c >> 1) ^ eth_rx_pkg::crc_poly) : (c >> 1);
            end
        end
        return ~c;
    endfunction

    task automatic build_payload(input int r);
        for (int i = 0; i < row_len[r]; i++) begin
            payload[i] = (i == 0) ? row_start[r] : 8'($random(seed));
            // noise must never look like a delimiter
            if (row_kind[r] == kind_no_sfd && payload[i] == eth_rx_pkg::sfd_byte) begin
                payload[i] = 8'h00;
            end
        end
    endtask

    task automatic drive_byte(input logic [7:0] d, input logic dv, input logic er);
        @(posedge clk);
        #1;
        gmii_rxd   = d;
        gmii_rx_dv = dv;
        gmii_rx_er = er;
    endtask

    task automatic send_row(input int r);
        logic [31:0] fcs;
        fcs = fcs_of(row_len[r]);
        if (row_bad_fcs[r]) begin
            fcs = fcs ^ 32'h0000_00FF;
        end
        for (int i = 0; i < 7; i++) begin
            drive_byte(8'h55, 1'b1, 1'b0);
        end
        if (row_kind[r] != kind_no_sfd) begin
            drive_byte(eth_rx_pkg::sfd_byte, 1'b1, row_kind[r] == kind_er_sfd);
        end
        for (int i = 0; i < row_len[r]; i++) begin
            drive_byte(payload[i], 1'b1, i == row_abort[r]);
            if (i == 0) begin
                first_drive_cycle = cycle_cnt;
            end
        end
        if (row_kind[r] != kind_no_sfd) begin
            // fcs goes out low byte first
            for (int k = 0; k < eth_rx_pkg::fcs_bytes; k++) begin
                drive_byte(fcs[8*k +: 8], 1'b1, 1'b0);
            end
        end
        drive_byte(8'h00, 1'b0, 1'b0);
    endtask

    task automatic wait_for_last(input int r);
        int limit;
        int n;
        limit = 2 * (row_len[r] + 8 + eth_rx_pkg::fcs_bytes) + 20;
        n = 0;
        while (!last_seen && n < limit) begin
            @(posedge clk);
            n++;
        end
        assert (last_seen) else begin
            $display("test %s timed out waiting for tlast after %0d cycles", row_name[r], limit);
            test_errors++;
        end
    endtask

    task automatic check_val(input string tname, input string what,
                             input logic [31:0] expected, input logic [31:0] actual);
        assert (expected == actual) else begin
            $display("[FAIL] %s %s: expected 0x%0h, actual 0x%0h", tname, what, expected, actual);
            test_errors++;
        end
    endtask

    task automatic check_row(input int r);
        int   n;
        int   n_last;
        int   n_user;
        logic bad;
        n      = beat_data.size();
        n_last = 0;
        n_user = 0;
        bad    = row_kind[r] == kind_frame && (row_bad_fcs[r] || row_abort[r] >= 0);
        foreach (beat_last[i]) begin
            n_last += int'(beat_last[i]);
            n_user += int'(beat_user[i]);
        end
        if (row_kind[r] != kind_frame) begin
            check_val(row_name[r], "beats", 0, n);
        end else if (row_abort[r] >= 0) begin
            // cut at or before the aborted byte
            assert (n >= 1 && n <= row_abort[r] + 1) else begin
                $display("[FAIL] %s beats: expected 1 to %0d, actual %0d",
                         row_name[r], row_abort[r] + 1, n);
                test_errors++;
            end
        end else begin
            check_val(row_name[r], "beats", row_len[r], n);
        end
        for (int i = 0; i < n && i < row_len[r]; i++) begin
            check_val(row_name[r], $sformatf("byte %0d", i), 32'(payload[i]), 32'(beat_data[i]));
        end
        if (n > 0) begin
            check_val(row_name[r], "tlast count", 1, n_last);
            check_val(row_name[r], "tlast on final beat", 1, 32'(beat_last[n-1]));
            check_val(row_name[r], "tuser count", bad ? 1 : 0, n_user);
            check_val(row_name[r], "tuser on final beat", 32'(bad), 32'(beat_user[n-1]));
        end
        check_val(row_name[r], "bad frame pulses", bad ? 1 : 0, bad_frame_pulses);
        check_val(row_name[r], "bad fcs pulses", row_bad_fcs[r] ? 1 : 0, bad_fcs_pulses);
        if (row_kind[r] == kind_frame && !bad && n > 0) begin
            check_val(row_name[r], "first beat cycle",
                      first_drive_cycle + 1 + eth_rx_pkg::rx_delay_depth, beat_cycle[0]);
        end
    endtask

    initial begin
        int exp_good;
        int exp_bad;
        int exp_fcs;
        clk              = 1'b0;
        reset_crc        = 1'b1;
        gmii_rxd         = 8'h00;
        gmii_rx_dv       = 1'b0;
        gmii_rx_er       = 1'b0;
        seed             = 32'h810a74d3;
        cycle_cnt        = 0;
        total_errors     = 0;
        tests_failed     = 0;
        last_seen        = 1'b0;
        bad_frame_pulses = 0;
        bad_fcs_pulses   = 0;
        exp_good         = 0;
        exp_bad          = 0;
        exp_fcs          = 0;
        load_table();

        repeat (10) @(posedge clk);
        #1;
        reset_crc = 1'b0;
        repeat (4) @(posedge clk);

        for (int r = 0; r < num_tests; r++) begin
            beat_data.delete();
            beat_last.delete();
            beat_user.delete();
            beat_cycle.delete();
            last_seen        = 1'b0;
            bad_frame_pulses = 0;
            bad_fcs_pulses   = 0;
            test_errors      = 0;
            build_payload(r);
            send_row(r);
            if (row_kind[r] == kind_frame) begin
                wait_for_last(r);
            end
            repeat (12) drive_byte(8'h00, 1'b0, 1'b0);
            check_row(r);
            // expected statistics from the table
            if (row_kind[r] == kind_frame) begin
                if (row_bad_fcs[r] || row_abort[r] >= 0) begin
                    exp_bad++;
                end else begin
                    exp_good++;
                end
                if (row_bad_fcs[r]) begin
                    exp_fcs++;
                end
            end
            if (test_errors == 0) begin
                $display("test %s: ok", row_name[r]);
            end else begin
                $display("test %s: %0d check(s) failed", row_name[r], test_errors);
                tests_failed++;
            end
            total_errors += test_errors;
        end

        test_errors = 0;
        check_val("counters", "cnt_good", exp_good, 32'(cnt_good));
        check_val("counters", "cnt_bad", exp_bad, 32'(cnt_bad));
        check_val("counters", "cnt_fcs", exp_fcs, 32'(cnt_fcs));
        if (test_errors == 0) begin
            $display("test counters: ok");
        end else begin
            $display("test counters: %0d check(s) failed", test_errors);
            tests_failed++;
        end
        total_errors += test_errors;

        $display("tests run %0d, tests failed %0d, checks failed %0d",
                 num_tests + 1, tests_failed, total_errors);
        if (total_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule
